// ==== hw/peakPkg.sv ====
// Sizes, correlation vector and result types, sequencer command and state enum
package peakPkg;

    // Sample and correlation sizes
    localparam int NUM_BITS_SAMPLE = 12;
    localparam int NUM_SAMPLES = 1024;
    localparam int MAX_LAGS = 17;
    localparam int NUM_LAGS = 2 * MAX_LAGS + 1;
    localparam int NUM_XCORRS = 2;
    localparam int NUM_BITS_XCORRS = 2 * NUM_BITS_SAMPLE + $clog2(NUM_SAMPLES);

    // Smallest peak that counts as a detection
    localparam int MIN_XCORR_VAL = 1000;

    // Signed lag covers -MAX_LAGS..+MAX_LAGS
    localparam int LAG_BITS = $clog2(MAX_LAGS + 1) + 1;
    localparam int IDX_BITS = $clog2(NUM_LAGS);

    typedef logic [NUM_BITS_XCORRS-1:0] xcorrValT;

    // Element 0 holds lag -MAX_LAGS
    typedef xcorrValT [NUM_LAGS-1:0] lagVecT;
    typedef lagVecT [NUM_XCORRS-1:0] xcorrBusT;

    typedef logic [IDX_BITS-1:0] lagIdxT;
    typedef logic signed [LAG_BITS-1:0] lagT;

    // One channel's result
    typedef struct packed {
        logic found;
        lagT lag;
    } peakResultT;

    typedef peakResultT [NUM_XCORRS-1:0] peakBusT;

    // Sequencer command, shared by all lanes
    typedef struct packed {
        logic load;
        logic step;
        lagIdxT idx;
        logic finish;
    } scanCtrlT;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } peakStateT;

endpackage

// ==== hw/peakFsm.sv ====
// Shared scan sequencer: lag index counter, lane commands and result strobe
`timescale 1ns/1ps

module peakFsm (
    input logic clk50M,
    input logic rstN,
    input logic dataInValid,
    output peakPkg::scanCtrlT scanCtrl,
    output logic dataOutValid
);

    peakPkg::peakStateT state;
    peakPkg::peakStateT nextState;
    peakPkg::lagIdxT idxCnt;
    logic lastIdx;
    logic accept;

    // Strobes are only taken while idle
    assign accept = (state == peakPkg::IDLE) && dataInValid;
    assign lastIdx = (idxCnt == peakPkg::lagIdxT'(peakPkg::NUM_LAGS - 1));

    always_comb begin
        nextState = state;
        case (state)
            peakPkg::IDLE: begin
                if (dataInValid) begin
                    nextState = peakPkg::SCAN;
                end
            end
            peakPkg::SCAN: begin
                if (lastIdx) begin
                    nextState = peakPkg::DONE;
                end
            end
            peakPkg::DONE: begin
                nextState = peakPkg::IDLE;
            end
            default: begin
                nextState = peakPkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk50M or negedge rstN) begin
        if (!rstN) begin
            state <= peakPkg::IDLE;
            idxCnt <= '0;
            dataOutValid <= 1'b0;
        end else begin
            state <= nextState;
            if (accept) begin
                idxCnt <= '0;
            end else if (state == peakPkg::SCAN && !lastIdx) begin
                idxCnt <= idxCnt + 1'b1;
            end
            // Result lands in the lanes on the finish edge
            dataOutValid <= scanCtrl.finish;
        end
    end

    // Lane commands
    always_comb begin
        scanCtrl.load = accept;
        scanCtrl.step = (state == peakPkg::SCAN);
        scanCtrl.idx = idxCnt;
        scanCtrl.finish = (state == peakPkg::DONE);
    end

    // One result strobe per accepted vector, never back to back
    assert property (@(posedge clk50M) disable iff (!rstN)
        dataOutValid |=> !dataOutValid)
        else $error("dataOutValid high on two consecutive cycles");

    // Lanes index their vector with idx during step
    assert property (@(posedge clk50M) disable iff (!rstN)
        scanCtrl.step |-> (scanCtrl.idx < peakPkg::NUM_LAGS))
        else $error("Lag index out of range during scan");

endmodule

// ==== hw/lagScanner.sv ====
// One channel scan lane: vector store, running maximum tracker and result register
`timescale 1ns/1ps

module lagScanner (
    input logic clk50M,
    input logic rstN,
    input peakPkg::scanCtrlT scanCtrl,
    input peakPkg::lagVecT lagVec,
    output peakPkg::peakResultT result
);

    // Captured correlation vector
    peakPkg::lagVecT vecReg;

    // Running maximum and where it was seen
    peakPkg::xcorrValT maxVal;
    peakPkg::lagIdxT maxIdx;

    // Value under test this cycle
    peakPkg::xcorrValT selVal;
    logic newMax;

    // Result computed from the final maximum
    logic foundNext;
    peakPkg::lagT lagNext;

    assign selVal = vecReg[scanCtrl.idx];

    // Strictly larger only, so the lowest index keeps a tie
    assign newMax = scanCtrl.step && (selVal > maxVal);

    always_ff @(posedge clk50M) begin
        if (scanCtrl.load) begin
            vecReg <= lagVec;
        end
    end

    always_ff @(posedge clk50M) begin
        if (scanCtrl.load) begin
            maxVal <= '0;
            maxIdx <= '0;
        end else if (newMax) begin
            maxVal <= selVal;
            maxIdx <= scanCtrl.idx;
        end
    end

    // Threshold test on the final maximum
    assign foundNext = (maxVal >= peakPkg::xcorrValT'(peakPkg::MIN_XCORR_VAL));

    // Index 0 maps to lag -MAX_LAGS, wraps cleanly in LAG_BITS
    always_comb begin
        if (foundNext) begin
            lagNext = peakPkg::lagT'(maxIdx - peakPkg::lagIdxT'(peakPkg::MAX_LAGS));
        end else begin
            lagNext = '0;
        end
    end

    // Result holds until the next finish
    always_ff @(posedge clk50M or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (scanCtrl.finish) begin
            result.found <= foundNext;
            result.lag <= lagNext;
        end
    end

    // Sequencer never loads a lane in the middle of a compare
    assert property (@(posedge clk50M) disable iff (!rstN)
        !(scanCtrl.load && scanCtrl.step))
        else $error("load and step high together");

endmodule

// ==== hw/peak.sv ====
// Peak search top level: shared sequencer and one scan lane per channel
`timescale 1ns/1ps

module peak (
    input logic clk50M,
    input logic rstN,
    input peakPkg::xcorrBusT dataIn,
    input logic dataInValid,
    output peakPkg::peakBusT dataOut,
    output logic dataOutValid
);

    // Command from the sequencer to all lanes
    peakPkg::scanCtrlT scanCtrl;

    peakFsm uFsm (
        .clk50M(clk50M),
        .rstN(rstN),
        .dataInValid(dataInValid),
        .scanCtrl(scanCtrl),
        .dataOutValid(dataOutValid)
    );

    // One lane per correlation channel, each owning its result slot
    genvar ch;
    generate
        for (ch = 0; ch < peakPkg::NUM_XCORRS; ch++) begin : gLane
            lagScanner uScanner (
                .clk50M(clk50M),
                .rstN(rstN),
                .scanCtrl(scanCtrl),
                .lagVec(dataIn[ch]),
                .result(dataOut[ch])
            );
        end
    endgenerate

endmodule

// ==== include/peakTbCases.svh ====
// Test case types and the stimulus table for the peak search testbench
`ifndef PEAK_TB_CASES_SVH
`define PEAK_TB_CASES_SVH

// Columns per channel: peak index, peak value, background limit, tie index (-1 for none)
typedef struct packed {
    int peakIdx;
    longint peakVal;
    longint bgLimit;
    int tieIdx;
} chanCaseT;

// Channel 0, channel 1, extra dataInValid pulse during the scan
typedef struct packed {
    chanCaseT ch0;
    chanCaseT ch1;
    bit midPulse;
} caseT;

localparam int NUM_CASES = 8;

caseT caseTable [NUM_CASES] = '{
    // Extreme indices, lags -17 and +17
    '{'{0, 5000, 900, -1}, '{34, 6000, 900, -1}, 1'b0},
    // Center lag on both, second one exactly at threshold
    '{'{17, 2000, 800, -1}, '{17, 1000, 999, -1}, 1'b0},
    // One below threshold
    '{'{5, 999, 999, -1}, '{30, 1500, 1000, -1}, 1'b0},
    // Equal maxima, lower index wins
    '{'{25, 3000, 1000, 9}, '{3, 3000, 1000, 31}, 1'b0},
    // Independent lanes, full width peak on channel 0
    '{'{2, 64'h3_FFFF_FFFF, 100000000, -1}, '{33, 123456789, 100000000, -1}, 1'b0},
    // Extra strobe in mid scan
    '{'{12, 4242, 2000, -1}, '{20, 7000, 3000, -1}, 1'b1},
    // All zero lane, threshold peak at index 0
    '{'{10, 0, 1, -1}, '{0, 1000, 1000, -1}, 1'b0},
    // Ties at both ends of the vector
    '{'{34, 1001, 1000, 0}, '{16, 50000, 40000, 18}, 1'b1}
};

`endif

// ==== sim/peakTb.sv ====
// Testbench for the peak search block: clock, reset, vector builder, reference model, checks
`timescale 1ns/1ps

module peakTb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int LATENCY = peakPkg::NUM_LAGS + 1;
    localparam int PULSE_CYCLE = 10;
    localparam int QUIET_CYCLES = 40;

    logic clk50M;
    logic rstN;
    peakPkg::xcorrBusT dataIn;
    logic dataInValid;
    peakPkg::peakBusT dataOut;
    logic dataOutValid;

    `include "peakTbCases.svh"

    peakPkg::xcorrBusT vecBus;
    peakPkg::xcorrBusT otherBus;
    peakPkg::peakBusT expBus;
    int riseCycle;

    peak DUT (
        .clk50M(clk50M),
        .rstN(rstN),
        .dataIn(dataIn),
        .dataInValid(dataInValid),
        .dataOut(dataOut),
        .dataOutValid(dataOutValid)
    );

    initial begin
        clk50M = 1'b0;
        forever #10 clk50M = ~clk50M;
    end

    task automatic stopWithFail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkResult(input string name, input peakPkg::peakResultT got,
                               input peakPkg::peakResultT exp);
        if (got !== exp) begin
            stopWithFail($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopWithFail($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Rise time against the fixed latency, then a one cycle width
    task automatic checkStrobe(input int rise);
        if (rise != LATENCY) begin
            stopWithFail($sformatf("Error: dataOutValid latency = 0x%0h, expected 0x%0h",
                                   rise, LATENCY));
        end
        @(posedge clk50M);
        #1;
        checkBit("dataOutValid", dataOutValid, 1'b0);
    endtask

    function automatic chanCaseT laneCase(input caseT tc, input int ch);
        if (ch == 0) begin
            return tc.ch0;
        end
        return tc.ch1;
    endfunction

    // Random background below the limit, then the peak and any tie entry
    function automatic peakPkg::lagVecT buildVec(input chanCaseT cc);
        peakPkg::lagVecT v;
        for (int i = 0; i < peakPkg::NUM_LAGS; i++) begin
            v[i] = peakPkg::xcorrValT'($urandom % cc.bgLimit);
        end
        v[cc.peakIdx] = peakPkg::xcorrValT'(cc.peakVal);
        if (cc.tieIdx >= 0) begin
            v[cc.tieIdx] = peakPkg::xcorrValT'(cc.peakVal);
        end
        return v;
    endfunction

    // First strict maximum, threshold test, lag relative to the center index
    function automatic peakPkg::peakResultT expectedPeak(input peakPkg::lagVecT v);
        peakPkg::peakResultT r;
        longint best;
        int bestIdx;
        best = v[0];
        bestIdx = 0;
        for (int i = 1; i < peakPkg::NUM_LAGS; i++) begin
            if (v[i] > best) begin
                best = v[i];
                bestIdx = i;
            end
        end
        r.found = (best >= peakPkg::MIN_XCORR_VAL);
        r.lag = r.found ? peakPkg::lagT'(bestIdx - peakPkg::MAX_LAGS) : '0;
        return r;
    endfunction

    // Counts edges after the accepting edge until the strobe shows up
    task automatic waitStrobe(input bit midPulse, input peakPkg::xcorrBusT other,
                              output int rise);
        int n;
        rise = 0;
        for (n = 1; n <= TIMEOUT_CYCLES; n++) begin
            @(posedge clk50M);
            #1;
            if (dataOutValid === 1'b1) begin
                rise = n;
                break;
            end
            if (midPulse && n == PULSE_CYCLE) begin
                #1;
                dataIn = other;
                dataInValid = 1'b1;
            end else if (midPulse && n == PULSE_CYCLE + 1) begin
                #1;
                dataInValid = 1'b0;
            end
        end
        if (rise == 0) begin
            stopWithFail("Timeout: dataOutValid did not rise within 100 cycles of the vector");
        end
    endtask

    task automatic expectQuiet(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk50M);
            #1;
            checkBit("dataOutValid", dataOutValid, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(81));
        rstN = 1'b0;
        dataIn = '0;
        dataInValid = 1'b0;
        expBus = '0;
        repeat (2) @(posedge clk50M);
        #2;
        rstN = 1'b1;
        #1;
        checkBit("dataOutValid", dataOutValid, 1'b0);

        for (int c = 0; c < NUM_CASES; c++) begin
            // Previous result (or reset value) must still be held
            for (int ch = 0; ch < peakPkg::NUM_XCORRS; ch++) begin
                checkResult($sformatf("dataOut[%0d]", ch), dataOut[ch], expBus[ch]);
            end
            for (int ch = 0; ch < peakPkg::NUM_XCORRS; ch++) begin
                vecBus[ch] = buildVec(laneCase(caseTable[c], ch));
                otherBus[ch] = buildVec(laneCase(caseTable[c], 1 - ch));
                expBus[ch] = expectedPeak(vecBus[ch]);
            end

            @(posedge clk50M);
            #2;
            dataIn = vecBus;
            dataInValid = 1'b1;
            @(posedge clk50M);
            #2;
            dataInValid = 1'b0;

            waitStrobe(caseTable[c].midPulse, otherBus, riseCycle);
            for (int ch = 0; ch < peakPkg::NUM_XCORRS; ch++) begin
                checkResult($sformatf("dataOut[%0d]", ch), dataOut[ch], expBus[ch]);
            end
            checkStrobe(riseCycle);
            if (caseTable[c].midPulse) begin
                expectQuiet(QUIET_CYCLES);
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hw/peakPkg.sv
hw/peakFsm.sv
hw/lagScanner.sv
hw/peak.sv
sim/peakTb.sv
